// File: include/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Address split
`define DC_TAG_W     20
`define DC_INDEX_W   8
`define DC_OFFSET_W  4
`define DC_ADDR_W    (`DC_TAG_W + `DC_INDEX_W + `DC_OFFSET_W)

// Data widths
`define DC_WORD_W    32
`define DC_LINE_W    128

// Geometry of the two ways
`define DC_SETS      256
`define DC_WORDS     4

`endif

// File: src/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

    typedef logic way_sel_t;

    typedef struct packed {
        logic                      op;
        logic [`DC_TAG_W-1:0]      tag;
        logic [`DC_INDEX_W-1:0]    index;
        logic [`DC_OFFSET_W-1:0]   offset;
        logic [`DC_WORD_W/8-1:0]   wstrb;
        logic [`DC_WORD_W-1:0]     wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                      v;
        logic [`DC_TAG_W-1:0]      tag;
    } tagv_t;

    typedef logic [`DC_WORDS-1:0][`DC_WORD_W-1:0] line_t;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0]     addr;
    } mem_rd_t;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0]     addr;
        line_t                     data;
    } mem_wr_t;

    // Byte-strobed merge of a store into one word
    function automatic logic [`DC_WORD_W-1:0] merge_word(
        input logic [`DC_WORD_W-1:0]   old_word,
        input logic [`DC_WORD_W-1:0]   new_word,
        input logic [`DC_WORD_W/8-1:0] strb
    );
        logic [`DC_WORD_W-1:0] res;
        res = old_word;
        for (int b = 0; b < `DC_WORD_W / 8; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: src/way_sram.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module way_sram #(
    parameter type word_t = logic [`DC_WORD_W-1:0]
) (
    input  logic                   clk,
    input  logic                   en,
    input  logic                   we,
    input  logic [`DC_INDEX_W-1:0] addr,
    input  word_t                  din,
    output word_t                  dout
);

    word_t mem [`DC_SETS];

    // Cleared contents, so every valid bit starts low
    initial begin
        for (int i = 0; i < `DC_SETS; i++) begin
            mem[i] = '0;
        end
    end

    // Read-first with one cycle of latency and dout held while en is low
    always @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
            end
            dout <= mem[addr];
        end
    end

endmodule

// File: src/lookup_decode.sv
`timescale 1ns/1ps

module lookup_decode (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 addr_ok,
    input  dcache_pkg::tagv_t    tag_dout0,
    input  dcache_pkg::tagv_t    tag_dout1,
    output dcache_pkg::cpu_req_t rb,
    output logic                 lookup,
    output logic                 hit,
    output dcache_pkg::way_sel_t hit_way
);

    logic accept;
    logic way0_hit;
    logic way1_hit;

    assign accept = valid && addr_ok;

    // Request buffer held until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            rb <= req;
        end
    end

    // Lookup follows the acceptance edge that reads the tag RAMs
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lookup <= 1'b0;
        end else begin
            lookup <= accept;
        end
    end

    // Tag compare against both ways
    assign way0_hit = tag_dout0.v && (tag_dout0.tag == rb.tag);
    assign way1_hit = tag_dout1.v && (tag_dout1.tag == rb.tag);

    // Only meaningful while lookup is high
    assign hit     = way0_hit || way1_hit;
    assign hit_way = way1_hit;

endmodule

// File: src/miss_engine.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module miss_engine (
    input  logic                    clk,
    input  logic                    resetn,
    input  dcache_pkg::cpu_req_t    rb,
    input  logic                    lookup,
    input  logic                    hit,
    input  dcache_pkg::tagv_t       tag_dout0,
    input  dcache_pkg::tagv_t       tag_dout1,
    input  dcache_pkg::line_t       line_dout0,
    input  dcache_pkg::line_t       line_dout1,
    input  logic                    victim_dirty,
    output logic                    idle,
    output logic                    fill_we,
    output dcache_pkg::way_sel_t    fill_way,
    output dcache_pkg::line_t       fill_line,
    output logic                    rd_req,
    output dcache_pkg::mem_rd_t     rd,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  dcache_pkg::line_t       ret_data,
    output logic                    wr_req,
    output dcache_pkg::mem_wr_t     wr,
    input  logic                    wr_rdy,
    output logic                    data_ok_miss,
    output logic [`DC_WORD_W-1:0]   miss_rdata
);

    typedef enum logic [4:0] {
        S_IDLE    = 5'b00001,
        S_LOOKUP  = 5'b00010,
        S_MISS    = 5'b00100,
        S_REPLACE = 5'b01000,
        S_REFILL  = 5'b10000
    } state_t;

    state_t                        state;
    state_t                        next_state;
    logic [7:0]                    lfsr;
    dcache_pkg::way_sel_t          rp_way;
    logic                          rp_v;
    logic                          rp_d;
    logic [`DC_TAG_W-1:0]          rp_tag;
    dcache_pkg::line_t             rp_data;
    logic                          write_back;
    logic                          wr_pulse;
    logic [$clog2(`DC_WORDS)-1:0]  word_sel;

    assign word_sel   = rb.offset[`DC_OFFSET_W-1:2];
    assign write_back = rp_v && rp_d;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: begin
                if (lookup && !hit) begin
                    next_state = S_LOOKUP;
                end
            end
            // RAM outputs still hold the lookup read here
            S_LOOKUP: next_state = S_MISS;
            S_MISS: begin
                if (!write_back || wr_rdy) begin
                    next_state = S_REPLACE;
                end
            end
            S_REPLACE: begin
                if (rd_rdy) begin
                    next_state = S_REFILL;
                end
            end
            S_REFILL: begin
                if (ret_valid) begin
                    next_state = S_IDLE;
                end
            end
            default: next_state = S_IDLE;
        endcase
    end

    // Victim way follows the LFSR until a miss freezes it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr   <= 8'h01;
            rp_way <= 1'b0;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (state == S_IDLE) begin
                rp_way <= lfsr[0];
            end
        end
    end

    // Miss buffer
    always_ff @(posedge clk) begin
        if (state == S_LOOKUP) begin
            rp_v    <= rp_way ? tag_dout1.v   : tag_dout0.v;
            rp_tag  <= rp_way ? tag_dout1.tag : tag_dout0.tag;
            rp_data <= rp_way ? line_dout1    : line_dout0;
            rp_d    <= victim_dirty;
        end
    end

    // Write-back request goes out on the first replace cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_pulse <= 1'b0;
        end else begin
            wr_pulse <= (state == S_MISS) && write_back && wr_rdy;
        end
    end

    // Store miss bytes land on top of the returned line
    always_comb begin
        fill_line = ret_data;
        if (rb.op) begin
            fill_line[word_sel] = dcache_pkg::merge_word(ret_data[word_sel], rb.wdata,
                                                         rb.wstrb);
        end
    end

    assign idle         = (state == S_IDLE) && !lookup;
    assign fill_we      = (state == S_REFILL) && ret_valid;
    assign fill_way     = rp_way;
    assign rd_req       = (state == S_REPLACE);
    assign rd.addr      = {rb.tag, rb.index, {`DC_OFFSET_W{1'b0}}};
    assign wr_req       = wr_pulse;
    assign wr.addr      = {rp_tag, rb.index, {`DC_OFFSET_W{1'b0}}};
    assign wr.data      = rp_data;
    assign data_ok_miss = fill_we;
    assign miss_rdata   = ret_data[word_sel];

endmodule

// File: src/hit_result.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module hit_result (
    input  logic                    clk,
    input  logic                    resetn,
    input  dcache_pkg::cpu_req_t    rb,
    input  logic                    lookup,
    input  logic                    hit,
    input  dcache_pkg::way_sel_t    hit_way,
    input  dcache_pkg::line_t       line_dout0,
    input  dcache_pkg::line_t       line_dout1,
    input  logic                    fill_we,
    input  dcache_pkg::way_sel_t    fill_way,
    input  logic                    data_ok_miss,
    input  logic [`DC_WORD_W-1:0]   miss_rdata,
    input  dcache_pkg::way_sel_t    victim_way,
    output logic                    wb_busy,
    output logic                    wb_we,
    output dcache_pkg::way_sel_t    wb_way,
    output logic [`DC_INDEX_W-1:0]  wb_index,
    output dcache_pkg::line_t       wb_line,
    output logic                    victim_dirty,
    output logic                    data_ok,
    output logic [`DC_WORD_W-1:0]   rdata
);

    logic [$clog2(`DC_WORDS)-1:0]  word_sel;
    logic                          lookup_hit;
    logic                          store_hit;
    logic                          wb_pending;
    dcache_pkg::line_t             hit_line;
    dcache_pkg::line_t             merged_line;
    logic [`DC_SETS-1:0][1:0]      dirty;

    assign word_sel   = rb.offset[`DC_OFFSET_W-1:2];
    assign lookup_hit = lookup && hit;
    assign store_hit  = lookup_hit && rb.op;
    assign hit_line   = hit_way ? line_dout1 : line_dout0;

    always_comb begin
        merged_line = hit_line;
        merged_line[word_sel] = dcache_pkg::merge_word(hit_line[word_sel], rb.wdata, rb.wstrb);
    end

    // Load word on a hit, refill word otherwise
    assign data_ok = lookup_hit || data_ok_miss;
    assign rdata   = lookup_hit ? hit_line[word_sel] : miss_rdata;

    // Write buffer holds the whole merged line for one cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_pending <= 1'b0;
        end else begin
            wb_pending <= store_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            wb_way   <= hit_way;
            wb_index <= rb.index;
            wb_line  <= merged_line;
        end
    end

    assign wb_we   = wb_pending;
    assign wb_busy = store_hit || wb_pending;

    // Dirty bits per set and way
    always_ff @(posedge clk) begin
        if (!resetn) begin
            dirty <= '0;
        end else if (wb_we) begin
            dirty[wb_index][wb_way] <= 1'b1;
        end else if (fill_we) begin
            dirty[rb.index][fill_way] <= rb.op;
        end
    end

    assign victim_dirty = dirty[rb.index][victim_way];

endmodule

// File: src/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    valid,
    input  dcache_pkg::cpu_req_t    req,
    output logic                    addr_ok,
    output logic                    data_ok,
    output logic [`DC_WORD_W-1:0]   rdata,
    output logic                    rd_req,
    output dcache_pkg::mem_rd_t     rd,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  dcache_pkg::line_t       ret_data,
    output logic                    wr_req,
    output dcache_pkg::mem_wr_t     wr,
    input  logic                    wr_rdy
);

    dcache_pkg::cpu_req_t          rb;
    logic                          lookup;
    logic                          hit;
    dcache_pkg::way_sel_t          hit_way;
    dcache_pkg::tagv_t             tag_dout [2];
    dcache_pkg::line_t             line_dout [2];
    logic                          me_idle;
    logic                          fill_we;
    dcache_pkg::way_sel_t          fill_way;
    dcache_pkg::line_t             fill_line;
    logic                          data_ok_miss;
    logic [`DC_WORD_W-1:0]         miss_rdata;
    logic                          victim_dirty;
    logic                          wb_busy;
    logic                          wb_we;
    dcache_pkg::way_sel_t          wb_way;
    logic [`DC_INDEX_W-1:0]        wb_index;
    dcache_pkg::line_t             wb_line;
    logic                          accept;
    logic [`DC_INDEX_W-1:0]        ram_addr;
    dcache_pkg::tagv_t             tag_din;
    dcache_pkg::line_t             line_din;

    assign addr_ok = valid && me_idle && !wb_busy;
    assign accept  = valid && addr_ok;

    // Write buffer, then refill, else the incoming request
    assign ram_addr = wb_we ? wb_index : (fill_we ? rb.index : req.index);
    assign tag_din  = '{v: 1'b1, tag: rb.tag};
    assign line_din = wb_we ? wb_line : fill_line;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic fill_sel;
        logic wb_sel;

        assign fill_sel = fill_we && (fill_way == 1'(w));
        assign wb_sel   = wb_we && (wb_way == 1'(w));

        way_sram #(.word_t(dcache_pkg::tagv_t)) u_tag (
            .clk  (clk),
            .en   (accept || fill_sel),
            .we   (fill_sel),
            .addr (ram_addr),
            .din  (tag_din),
            .dout (tag_dout[w])
        );

        way_sram #(.word_t(dcache_pkg::line_t)) u_data (
            .clk  (clk),
            .en   (accept || fill_sel || wb_sel),
            .we   (fill_sel || wb_sel),
            .addr (ram_addr),
            .din  (line_din),
            .dout (line_dout[w])
        );
    end

    lookup_decode u_lookup (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .tag_dout0 (tag_dout[0]),
        .tag_dout1 (tag_dout[1]),
        .rb        (rb),
        .lookup    (lookup),
        .hit       (hit),
        .hit_way   (hit_way)
    );

    miss_engine u_miss (
        .clk          (clk),
        .resetn       (resetn),
        .rb           (rb),
        .lookup       (lookup),
        .hit          (hit),
        .tag_dout0    (tag_dout[0]),
        .tag_dout1    (tag_dout[1]),
        .line_dout0   (line_dout[0]),
        .line_dout1   (line_dout[1]),
        .victim_dirty (victim_dirty),
        .idle         (me_idle),
        .fill_we      (fill_we),
        .fill_way     (fill_way),
        .fill_line    (fill_line),
        .rd_req       (rd_req),
        .rd           (rd),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .wr_req       (wr_req),
        .wr           (wr),
        .wr_rdy       (wr_rdy),
        .data_ok_miss (data_ok_miss),
        .miss_rdata   (miss_rdata)
    );

    hit_result u_result (
        .clk          (clk),
        .resetn       (resetn),
        .rb           (rb),
        .lookup       (lookup),
        .hit          (hit),
        .hit_way      (hit_way),
        .line_dout0   (line_dout[0]),
        .line_dout1   (line_dout[1]),
        .fill_we      (fill_we),
        .fill_way     (fill_way),
        .data_ok_miss (data_ok_miss),
        .miss_rdata   (miss_rdata),
        .victim_way   (fill_way),
        .wb_busy      (wb_busy),
        .wb_we        (wb_we),
        .wb_way       (wb_way),
        .wb_index     (wb_index),
        .wb_line      (wb_line),
        .victim_dirty (victim_dirty),
        .data_ok      (data_ok),
        .rdata        (rdata)
    );

endmodule

// File: sim/dcache_chk.sv
`timescale 1ns/1ps

module dcache_chk (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  logic                addr_ok,
    input  logic                data_ok,
    input  logic                rd_req,
    input  logic                rd_rdy,
    input  dcache_pkg::mem_rd_t rd,
    input  logic                wr_req
);

    int         fail_count = 0;
    logic [1:0] outstanding;

    // Accepted requests still waiting for data_ok
    always_ff @(posedge clk) begin
        if (!resetn) begin
            outstanding <= 2'd0;
        end else begin
            outstanding <= outstanding + 2'(valid && addr_ok) - 2'(data_ok);
        end
    end

    rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd))
        else begin
            fail_count++;
            $error("rd_req dropped or changed before rd_rdy");
        end

    wr_single: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |=> !wr_req)
        else begin
            fail_count++;
            $error("wr_req held longer than one cycle");
        end

    data_ok_owned: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> outstanding != 2'd0)
        else begin
            fail_count++;
            $error("data_ok without an accepted request");
        end

endmodule

// File: sim/dcache_monitor.sv
`timescale 1ns/1ps

module dcache_monitor #(
    parameter int LIMIT = 40
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 valid,
    input  logic                 addr_ok,
    input  dcache_pkg::cpu_req_t req,
    input  logic                 data_ok,
    input  logic [31:0]          rdata,
    input  logic [15:0]          test_id,
    input  logic [31:0]          exp_rdata,
    input  logic                 check_hit,
    output int                   done_count,
    output int                   fail_count
);

    logic        pending;
    int          cycles;
    logic        cur_op;
    logic        cur_hit;
    logic [15:0] cur_id;
    logic [31:0] cur_exp;
    logic [31:0] cur_addr;
    logic        ok;

    always @(posedge clk) begin
        if (!resetn) begin
            pending    = 1'b0;
            done_count = 0;
            fail_count = 0;
        end else begin
            if (pending) begin
                cycles++;
                if (data_ok) begin
                    ok = 1'b1;
                    if (!cur_op && rdata !== cur_exp) begin
                        $display("MISMATCH t=%0t test %0d rdata expected %h actual %h",
                                 $time, cur_id, cur_exp, rdata);
                        ok = 1'b0;
                    end
                    // Hit latency is exactly one cycle
                    if (cur_hit && cycles != 1) begin
                        $display("MISMATCH t=%0t test %0d data_ok latency expected 1 actual %0d",
                                 $time, cur_id, cycles);
                        ok = 1'b0;
                    end
                    $display("test %0d %s %h: %s", cur_id, cur_op ? "store" : "load ",
                             cur_addr, ok ? "ok" : "FAILED");
                    done_count++;
                    if (!ok) begin
                        fail_count++;
                    end
                    pending = 1'b0;
                end else if (cycles >= LIMIT) begin
                    $display("test %0d: no data_ok within %0d cycles of acceptance",
                             cur_id, LIMIT);
                    done_count++;
                    fail_count++;
                    pending = 1'b0;
                end
            end else if (data_ok) begin
                $display("data_ok seen at t=%0t with no request outstanding", $time);
                fail_count++;
            end
            if (valid && addr_ok) begin
                pending  = 1'b1;
                cycles   = 0;
                cur_op   = req.op;
                cur_hit  = check_hit;
                cur_id   = test_id;
                cur_exp  = exp_rdata;
                cur_addr = {req.tag, req.index, req.offset};
            end
        end
    end

endmodule

// File: sim/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb;

    localparam int          CLK_PERIOD      = 100;
    localparam int          MAX_TESTS       = 64;
    localparam int          CYCLES_PER_TEST = 40;
    localparam logic [31:0] SEED            = 32'he7630562;
    localparam logic [31:0] SALT            = 32'h5a5a0000;

    logic                 clk = 1'b0;
    logic                 resetn;
    logic                 valid;
    dcache_pkg::cpu_req_t req;
    logic                 addr_ok;
    logic                 data_ok;
    logic [31:0]          rdata;
    logic                 rd_req;
    dcache_pkg::mem_rd_t  rd;
    logic                 rd_rdy = 1'b0;
    logic                 ret_valid = 1'b0;
    dcache_pkg::line_t    ret_data = '0;
    logic                 wr_req;
    dcache_pkg::mem_wr_t  wr;
    logic                 wr_rdy = 1'b1;

    logic [15:0]          test_id;
    logic [31:0]          exp_rdata;
    logic                 check_hit;
    logic [107:0]         tests [MAX_TESTS];
    int                   num_tests = 0;
    int                   done_count;
    int                   mon_fail;
    int                   drive_fail = 0;

    // Memory model state
    logic [31:0]          rng = SEED;
    logic [31:0]          mem_words [logic [29:0]];
    logic                 ret_pending = 1'b0;
    logic [31:0]          ret_addr;
    int                   ret_wait;
    int                   stall = -1;
    logic                 handshake;

    always #(CLK_PERIOD / 2) clk = ~clk;

    dcache_top UUT (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .req       (req),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd        (rd),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr        (wr),
        .wr_rdy    (wr_rdy)
    );

    dcache_monitor #(.LIMIT(CYCLES_PER_TEST)) u_mon (
        .clk        (clk),
        .resetn     (resetn),
        .valid      (valid),
        .addr_ok    (addr_ok),
        .req        (req),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .test_id    (test_id),
        .exp_rdata  (exp_rdata),
        .check_hit  (check_hit),
        .done_count (done_count),
        .fail_count (mon_fail)
    );

    bind dcache_top dcache_chk u_chk (
        .clk     (clk),
        .resetn  (resetn),
        .valid   (valid),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rd_req  (rd_req),
        .rd_rdy  (rd_rdy),
        .rd      (rd),
        .wr_req  (wr_req)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function logic [31:0] draw_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Unwritten words read as word address XOR salt
    function dcache_pkg::line_t read_line(input logic [31:0] addr);
        dcache_pkg::line_t line;
        logic [29:0]       waddr;
        for (int i = 0; i < `DC_WORDS; i++) begin
            waddr = addr[31:2] + 30'(i);
            if (mem_words.exists(waddr)) begin
                line[i] = mem_words[waddr];
            end else begin
                line[i] = {2'b00, waddr} ^ SALT;
            end
        end
        return line;
    endfunction

    task store_line(input logic [31:0] addr, input dcache_pkg::line_t data);
        for (int i = 0; i < `DC_WORDS; i++) begin
            mem_words[addr[31:2] + 30'(i)] = data[i];
        end
    endtask

    // Memory model with random 0..3 cycle rd_rdy stall and return delay
    always @(posedge clk) begin
        handshake = rd_req && rd_rdy;
        if (wr_req) begin
            store_line(wr.addr, wr.data);
        end
        if (handshake) begin
            ret_pending = 1'b1;
            ret_addr    = rd.addr;
            ret_wait    = int'(draw_random() % 4);
        end
        #1;
        ret_valid = 1'b0;
        rd_rdy    = 1'b0;
        if (!resetn) begin
            ret_pending = 1'b0;
            stall       = -1;
        end else begin
            if (ret_pending && !handshake) begin
                if (ret_wait == 0) begin
                    ret_valid   = 1'b1;
                    ret_data    = read_line(ret_addr);
                    ret_pending = 1'b0;
                end else begin
                    ret_wait--;
                end
            end
            if (rd_req) begin
                if (stall < 0) begin
                    stall = int'(draw_random() % 4);
                end
                if (stall == 0) begin
                    rd_rdy = 1'b1;
                    stall  = -1;
                end else begin
                    stall--;
                end
            end
            // Write side ready three cycles in four
            wr_rdy = (draw_random() % 4) != 0;
        end
    end

    initial begin
        longint limit;
        #1;
        limit = longint'(num_tests + 2) * CYCLES_PER_TEST * CLK_PERIOD;
        #(limit);
        $display("Watchdog expired after %0d ns, tests did not complete", limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [107:0] t;
        int           waited;
        int           chk_fail;
        logic         failed;
        resetn    = 1'b0;
        valid     = 1'b0;
        req       = '0;
        test_id   = '0;
        exp_rdata = '0;
        check_hit = 1'b0;
        for (int i = 0; i < MAX_TESTS; i++) begin
            tests[i] = '1;
        end
        $readmemh("sim/dcache_tests.txt", tests);
        while (num_tests < MAX_TESTS && tests[num_tests][107:104] != 4'hf) begin
            num_tests++;
        end
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < num_tests; i++) begin
            t         = tests[i];
            valid     = 1'b1;
            req.op    = t[104];
            req.tag   = t[99:80];
            req.index = t[79:72];
            req.offset = t[71:68];
            req.wstrb = t[67:64];
            req.wdata = t[63:32];
            exp_rdata = t[31:0];
            check_hit = t[100];
            test_id   = 16'(i + 1);
            waited    = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!addr_ok && waited < CYCLES_PER_TEST);
            if (!addr_ok) begin
                $display("test %0d: request was not accepted within %0d cycles",
                         i + 1, CYCLES_PER_TEST);
                drive_fail++;
                #1;
                valid = 1'b0;
                continue;
            end
            #1;
            valid = 1'b0;
            req   = '0;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!data_ok && waited < CYCLES_PER_TEST);
            #1;
        end
        repeat (2) @(posedge clk);
        chk_fail = UUT.u_chk.fail_count;
        failed = (num_tests == 0) || (mon_fail != 0) || (drive_fail != 0) ||
                 (chk_fail != 0) || (done_count != num_tests);
        $display("tests %0d, finished %0d, failed %0d, not accepted %0d, assertion failures %0d",
                 num_tests, done_count, mon_fail, drive_fail, chk_fail);
        if (failed) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+include
src/dcache_pkg.sv
src/way_sram.sv
src/lookup_decode.sv
src/miss_engine.sv
src/hit_result.sv
src/dcache_top.sv
sim/dcache_chk.sv
sim/dcache_monitor.sv
sim/dcache_tb.sv

// File: Makefile
# Verilator build and run of the data cache testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dcache_tb
FILELIST = src.f
PASS_MSG = Simulation finished: PASS

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: sim/dcache_tests.txt
// op hit addr wstrb wdata expected
// op 0 load, 1 store; hit 1 requires data_ok one cycle after acceptance
0_0_00001000_0_00000000_5A5A0400
0_1_00001004_0_00000000_5A5A0401
0_1_00001000_0_00000000_5A5A0400
1_1_00001008_3_DEADBEEF_00000000
0_1_00001008_0_00000000_5A5ABEEF
1_0_00002024_C_12345678_00000000
0_1_00002024_0_00000000_12340809
0_1_00002020_0_00000000_5A5A0808
1_0_00003050_F_AAAA0001_00000000
1_0_00004054_F_BBBB0002_00000000
1_0_0000505C_1_000000CC_00000000
0_0_00003050_0_00000000_AAAA0001
0_0_00004054_0_00000000_BBBB0002
0_0_0000505C_0_00000000_5A5A14CC
0_0_00003058_0_00000000_5A5A0C16
0_0_00004050_0_00000000_5A5A1014
1_0_00005050_F_CCCC0003_00000000
0_1_00005050_0_00000000_CCCC0003
0_1_0000505C_0_00000000_5A5A14CC
0_0_00001000_0_00000000_5A5A0400
0_0_00001008_0_00000000_5A5ABEEF
0_0_00006000_0_00000000_5A5A1800
0_0_00007004_0_00000000_5A5A1C01
0_0_00001008_0_00000000_5A5ABEEF
1_0_0000700C_8_77000000_00000000
0_1_0000700C_0_00000000_775A1C03
0_0_00006000_0_00000000_5A5A1800
0_0_0000100C_0_00000000_5A5A0403
